/* common/armControlPkg.sv */
package armControlPkg;

  // Decoder only sees bits 31:4 of the instruction word
  typedef logic [31:4] instrT;
  typedef logic [3:0]  condT;
  typedef logic [3:0]  flagsT;      // N Z C V, N on top
  typedef logic [3:0]  aluCtrlT;
  typedef logic [1:0]  regSrcT;
  typedef logic [1:0]  immSrcT;
  typedef logic [1:0]  flagWriteT;  // [1] N and Z, [0] C and V
  typedef logic [1:0]  fwdSelT;
  typedef logic [6:4]  shiftOpT;    // Keeps the instruction bit numbering

  // Forwarding mux selects for the E stage operands
  localparam fwdSelT fwdRegFile = 2'd0;
  localparam fwdSelT fwdResultW = 2'd1;
  localparam fwdSelT fwdAluM    = 2'd2;

  localparam aluCtrlT aluAdd = 4'b0100;  // Address calc for memory and branch

  // ARM condition field encodings
  localparam condT condEq = 4'd0;
  localparam condT condNe = 4'd1;
  localparam condT condCs = 4'd2;
  localparam condT condCc = 4'd3;
  localparam condT condMi = 4'd4;
  localparam condT condPl = 4'd5;
  localparam condT condVs = 4'd6;
  localparam condT condVc = 4'd7;
  localparam condT condHi = 4'd8;
  localparam condT condLs = 4'd9;
  localparam condT condGe = 4'd10;
  localparam condT condLt = 4'd11;
  localparam condT condGt = 4'd12;
  localparam condT condLe = 4'd13;
  localparam condT condAl = 4'd14;

endpackage

/* controller/instrDecoder.sv */
module instrDecoder (
  input  armControlPkg::instrT     InstrD,
  input  armControlPkg::shiftOpT   shiftOpCodeD,
  output armControlPkg::regSrcT    RegSrcD,
  output armControlPkg::immSrcT    ImmSrcD,
  output logic                     ALUSrcD,
  output logic                     MemtoRegD,
  output logic                     RegWriteD,
  output logic                     MemWriteD,
  output logic                     BranchD,
  output armControlPkg::aluCtrlT   ALUControlD,
  output armControlPkg::flagWriteT FlagWriteD,
  output logic                     multSelect,
  output logic                     RselectD,
  output logic [1:0]               resultSelectD,
  output logic                     PCSrcD
);

  logic [10:0] controlsD;
  logic        aluOpD;
  logic        rsrSelectD;

  // Control word layout
  // RegSrc(2) ImmSrc(2) ALUSrc MemtoReg RegWrite MemWrite Branch ALUOp mult
  always_comb begin
    case (InstrD[27:26])
      2'b00: begin
        if (InstrD[25]) begin
          controlsD = 11'b00_00_1010010;      // DP immediate
        end else if (InstrD[7] && InstrD[4]) begin
          controlsD = 11'b00_00_0010011;      // MUL
        end else begin
          controlsD = 11'b00_00_0010010;      // DP register
        end
      end
      2'b01: begin
        if (InstrD[20]) begin
          controlsD = 11'b00_01_1110000;      // LDR
        end else begin
          controlsD = 11'b10_01_1001000;      // STR
        end
      end
      2'b10:   controlsD = 11'b01_10_1000100; // B
      default: controlsD = 11'b0;             // Unsupported class acts as a bubble
    endcase
  end

  assign {RegSrcD, ImmSrcD, ALUSrcD, MemtoRegD,
          RegWriteD, MemWriteD, BranchD, aluOpD, multSelect} = controlsD;

  always_comb begin
    if (aluOpD) begin
      ALUControlD = InstrD[24:21];         // Opcode field drives the ALU directly
      FlagWriteD  = {InstrD[20], InstrD[20]};  // S bit
    end else begin
      ALUControlD = armControlPkg::aluAdd;
      FlagWriteD  = 2'b00;
    end
  end

  // R15 as destination is a PC write like a branch
  assign PCSrcD = ((InstrD[15:12] == 4'b1111) && RegWriteD) || BranchD;

  // Bit 4 tells shift by immediate from shift by register
  assign RselectD      = (InstrD[27:25] == 3'b000) && !shiftOpCodeD[4];
  assign rsrSelectD    = (InstrD[27:25] == 3'b000) && shiftOpCodeD[4];
  assign resultSelectD = {multSelect, rsrSelectD};

endmodule

/* controller/condUnit.sv */
module condUnit (
  input  armControlPkg::condT      CondE,
  input  armControlPkg::flagsT     FlagsE,
  input  armControlPkg::flagsT     ALUFlagsE,
  input  armControlPkg::flagWriteT FlagWriteE,
  output logic                     CondExE,
  output armControlPkg::flagsT     FlagsNextE
);

  logic neg, zero, carry, overflow;
  logic ge;

  assign {neg, zero, carry, overflow} = FlagsE;
  assign ge = (neg == overflow);  // Signed greater or equal

  always_comb begin
    case (CondE)
      armControlPkg::condEq: CondExE = zero;
      armControlPkg::condNe: CondExE = !zero;
      armControlPkg::condCs: CondExE = carry;
      armControlPkg::condCc: CondExE = !carry;
      armControlPkg::condMi: CondExE = neg;
      armControlPkg::condPl: CondExE = !neg;
      armControlPkg::condVs: CondExE = overflow;
      armControlPkg::condVc: CondExE = !overflow;
      armControlPkg::condHi: CondExE = carry && !zero;
      armControlPkg::condLs: CondExE = !carry || zero;
      armControlPkg::condGe: CondExE = ge;
      armControlPkg::condLt: CondExE = !ge;
      armControlPkg::condGt: CondExE = !zero && ge;
      armControlPkg::condLe: CondExE = zero || !ge;
      armControlPkg::condAl: CondExE = 1'b1;
      default:               CondExE = 1'b0;  // 4'b1111 never executes here
    endcase
  end

  // Flags only move when the instruction actually executes
  always_comb begin
    FlagsNextE = FlagsE;
    if (CondExE && FlagWriteE[1]) begin
      FlagsNextE[3:2] = ALUFlagsE[3:2];  // N Z
    end
    if (CondExE && FlagWriteE[0]) begin
      FlagsNextE[1:0] = ALUFlagsE[1:0];  // C V
    end
  end

endmodule

/* controller/controller.sv */
module controller (
  input  logic                   clk,
  input  logic                   reset,
  input  armControlPkg::instrT   InstrD,
  input  armControlPkg::flagsT   ALUFlagsE,
  input  logic                   FlushE,
  input  logic                   StallE,
  input  logic                   StallM,
  input  logic                   FlushW,
  input  logic                   doNotWriteReg,
  input  logic                   prevRSRstateD,
  input  armControlPkg::shiftOpT shiftOpCodeD,
  output armControlPkg::regSrcT  RegSrcD,
  output armControlPkg::immSrcT  ImmSrcD,
  output logic                   ALUSrcE,
  output logic                   BranchTakenE,
  output armControlPkg::aluCtrlT ALUControlE,
  output logic                   MemWriteM,
  output logic                   MemtoRegE,
  output logic                   MemtoRegM,
  output logic                   MemtoRegW,
  output logic                   RegWriteM,
  output logic                   RegWriteW,
  output logic                   PCSrcW,
  output logic                   PCWrPendingF,
  output logic [1:0]             previousCVflag,
  output logic                   RselectE,
  output logic                   prevRSRstateE,
  output logic [1:0]             resultSelectE,
  output armControlPkg::shiftOpT shiftOpCodeE,
  output logic                   multSelect
);

  logic                     ALUSrcD, MemtoRegD, RegWriteD, MemWriteD, BranchD;
  logic                     PCSrcD, RselectD;
  logic [1:0]               resultSelectD;
  armControlPkg::aluCtrlT   ALUControlD;
  armControlPkg::flagWriteT FlagWriteD, FlagWriteE;

  logic                     RegWriteE, MemWriteE, BranchE, PCSrcE;
  logic                     CondExE;
  logic                     RegWriteGatedE, MemWriteGatedE, PCSrcGatedE;
  armControlPkg::condT      CondE;
  armControlPkg::flagsT     FlagsE, FlagsNextE;

  logic                     PCSrcM;

  instrDecoder decoder (
    .InstrD        (InstrD),
    .shiftOpCodeD  (shiftOpCodeD),
    .RegSrcD       (RegSrcD),
    .ImmSrcD       (ImmSrcD),
    .ALUSrcD       (ALUSrcD),
    .MemtoRegD     (MemtoRegD),
    .RegWriteD     (RegWriteD),
    .MemWriteD     (MemWriteD),
    .BranchD       (BranchD),
    .ALUControlD   (ALUControlD),
    .FlagWriteD    (FlagWriteD),
    .multSelect    (multSelect),
    .RselectD      (RselectD),
    .resultSelectD (resultSelectD),
    .PCSrcD        (PCSrcD)
  );

  // Execute stage registers, flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || FlushE) begin
      {FlagWriteE, BranchE, MemWriteE, RegWriteE, PCSrcE, MemtoRegE} <= '0;
      {ALUSrcE, ALUControlE, CondE}                                   <= '0;
      {RselectE, resultSelectE, prevRSRstateE, shiftOpCodeE}          <= '0;
    end else if (!StallE) begin
      FlagWriteE    <= FlagWriteD;
      BranchE       <= BranchD;
      MemWriteE     <= MemWriteD;
      RegWriteE     <= RegWriteD;
      PCSrcE        <= PCSrcD;
      MemtoRegE     <= MemtoRegD;
      ALUSrcE       <= ALUSrcD;
      ALUControlE   <= ALUControlD;
      CondE         <= InstrD[31:28];
      RselectE      <= RselectD;
      resultSelectE <= resultSelectD;
      prevRSRstateE <= prevRSRstateD;
      shiftOpCodeE  <= shiftOpCodeD;
    end
  end

  // Flags update as the instruction leaves E
  always_ff @(posedge clk) begin
    if (reset) begin
      FlagsE <= '0;
    end else if (!StallE) begin
      FlagsE <= FlagsNextE;
    end
  end

  condUnit cond (
    .CondE      (CondE),
    .FlagsE     (FlagsE),
    .ALUFlagsE  (ALUFlagsE),
    .FlagWriteE (FlagWriteE),
    .CondExE    (CondExE),
    .FlagsNextE (FlagsNextE)
  );

  assign BranchTakenE   = BranchE && CondExE;
  assign MemWriteGatedE = MemWriteE && CondExE;
  assign PCSrcGatedE    = PCSrcE && CondExE;
  // Micro-op sequencer can block the register write of a DP step
  assign RegWriteGatedE = RegWriteE && CondExE && !doNotWriteReg;

  assign previousCVflag = FlagsE[1:0];  // Carry in for ADC, SBC and friends

  // Memory stage
  always_ff @(posedge clk) begin
    if (reset) begin
      {MemWriteM, MemtoRegM, RegWriteM, PCSrcM} <= '0;
    end else if (!StallM) begin
      MemWriteM <= MemWriteGatedE;
      MemtoRegM <= MemtoRegE;
      RegWriteM <= RegWriteGatedE;
      PCSrcM    <= PCSrcGatedE;
    end
  end

  // Writeback stage
  always_ff @(posedge clk) begin
    if (reset || FlushW) begin
      {MemtoRegW, RegWriteW, PCSrcW} <= '0;
    end else begin
      MemtoRegW <= MemtoRegM;
      RegWriteW <= RegWriteM;
      PCSrcW    <= PCSrcM;
    end
  end

  // Any PC write still ahead of W holds fetch
  assign PCWrPendingF = PCSrcD || PCSrcE || PCSrcM;

endmodule

/* source/hazardUnit.sv */
module hazardUnit (
  input  logic                  Match1EM,
  input  logic                  Match2EM,
  input  logic                  Match1EW,
  input  logic                  Match2EW,
  input  logic                  Match12DE,
  input  logic                  RegWriteM,
  input  logic                  RegWriteW,
  input  logic                  MemtoRegE,
  input  logic                  PCWrPendingF,
  input  logic                  PCSrcW,
  input  logic                  BranchTakenE,
  input  logic                  memBusy,
  output armControlPkg::fwdSelT ForwardAE,
  output armControlPkg::fwdSelT ForwardBE,
  output logic                  StallF,
  output logic                  StallD,
  output logic                  StallE,
  output logic                  StallM,
  output logic                  FlushD,
  output logic                  FlushE,
  output logic                  FlushW
);

  logic ldrStallD;
  logic pcStallF;

  // M result is newer than W, so it wins
  function automatic armControlPkg::fwdSelT fwdSelect(input logic matchM,
                                                      input logic matchW);
    armControlPkg::fwdSelT sel;
    if (matchM && RegWriteM) begin
      sel = armControlPkg::fwdAluM;
    end else if (matchW && RegWriteW) begin
      sel = armControlPkg::fwdResultW;
    end else begin
      sel = armControlPkg::fwdRegFile;
    end
    return sel;
  endfunction

  assign ForwardAE = fwdSelect(Match1EM, Match1EW);
  assign ForwardBE = fwdSelect(Match2EM, Match2EW);

  // Load in E feeding the instruction in D
  assign ldrStallD = Match12DE && MemtoRegE;

  // Fetch waits on a PC write until it reaches W
  assign pcStallF = PCWrPendingF && !PCSrcW;

  // memBusy freezes F..M and drains W, nothing else may flush meanwhile
  assign StallF = memBusy || ldrStallD || pcStallF;
  assign StallD = memBusy || ldrStallD;
  assign StallE = memBusy;
  assign StallM = memBusy;

  assign FlushD = !memBusy && (PCWrPendingF || PCSrcW || BranchTakenE);
  assign FlushE = !memBusy && (ldrStallD || BranchTakenE);
  assign FlushW = memBusy;

endmodule

/* source/armControlTop.sv */
module armControlTop (
  input  logic                   clk,
  input  logic                   reset,
  input  armControlPkg::instrT   InstrD,
  input  armControlPkg::flagsT   ALUFlagsE,
  input  logic                   doNotWriteReg,
  input  logic                   prevRSRstateD,
  input  armControlPkg::shiftOpT shiftOpCodeD,
  input  logic                   Match1EM,
  input  logic                   Match2EM,
  input  logic                   Match1EW,
  input  logic                   Match2EW,
  input  logic                   Match12DE,
  input  logic                   memBusy,
  output armControlPkg::regSrcT  RegSrcD,
  output armControlPkg::immSrcT  ImmSrcD,
  output logic                   ALUSrcE,
  output logic                   BranchTakenE,
  output armControlPkg::aluCtrlT ALUControlE,
  output logic                   MemWriteM,
  output logic                   MemtoRegE,
  output logic                   MemtoRegM,
  output logic                   MemtoRegW,
  output logic                   RegWriteM,
  output logic                   RegWriteW,
  output logic                   PCSrcW,
  output logic                   PCWrPendingF,
  output logic [1:0]             previousCVflag,
  output logic                   RselectE,
  output logic                   prevRSRstateE,
  output logic [1:0]             resultSelectE,
  output armControlPkg::shiftOpT shiftOpCodeE,
  output logic                   multSelect,
  output logic                   StallF,
  output logic                   StallD,
  output logic                   FlushD,
  output armControlPkg::fwdSelT  ForwardAE,
  output armControlPkg::fwdSelT  ForwardBE
);

  // Hazard unit back to controller
  logic StallE, StallM, FlushE, FlushW;

  controller ctrl (
    .clk            (clk),
    .reset          (reset),
    .InstrD         (InstrD),
    .ALUFlagsE      (ALUFlagsE),
    .FlushE         (FlushE),
    .StallE         (StallE),
    .StallM         (StallM),
    .FlushW         (FlushW),
    .doNotWriteReg  (doNotWriteReg),
    .prevRSRstateD  (prevRSRstateD),
    .shiftOpCodeD   (shiftOpCodeD),
    .RegSrcD        (RegSrcD),
    .ImmSrcD        (ImmSrcD),
    .ALUSrcE        (ALUSrcE),
    .BranchTakenE   (BranchTakenE),
    .ALUControlE    (ALUControlE),
    .MemWriteM      (MemWriteM),
    .MemtoRegE      (MemtoRegE),
    .MemtoRegM      (MemtoRegM),
    .MemtoRegW      (MemtoRegW),
    .RegWriteM      (RegWriteM),
    .RegWriteW      (RegWriteW),
    .PCSrcW         (PCSrcW),
    .PCWrPendingF   (PCWrPendingF),
    .previousCVflag (previousCVflag),
    .RselectE       (RselectE),
    .prevRSRstateE  (prevRSRstateE),
    .resultSelectE  (resultSelectE),
    .shiftOpCodeE   (shiftOpCodeE),
    .multSelect     (multSelect)
  );

  hazardUnit hazard (
    .Match1EM     (Match1EM),
    .Match2EM     (Match2EM),
    .Match1EW     (Match1EW),
    .Match2EW     (Match2EW),
    .Match12DE    (Match12DE),
    .RegWriteM    (RegWriteM),
    .RegWriteW    (RegWriteW),
    .MemtoRegE    (MemtoRegE),
    .PCWrPendingF (PCWrPendingF),
    .PCSrcW       (PCSrcW),
    .BranchTakenE (BranchTakenE),
    .memBusy      (memBusy),
    .ForwardAE    (ForwardAE),
    .ForwardBE    (ForwardBE),
    .StallF       (StallF),
    .StallD       (StallD),
    .StallE       (StallE),
    .StallM       (StallM),
    .FlushD       (FlushD),
    .FlushE       (FlushE),
    .FlushW       (FlushW)
  );

endmodule

/* test/armControlTb_assert.sv */
module pipelineChecks (
  input logic                   clk,
  input logic                   reset,
  input logic                   FlushE,
  input logic                   StallM,
  input logic                   MemWriteM,
  input logic                   MemtoRegM,
  input logic                   RegWriteM,
  input logic                   ALUSrcE,
  input logic                   MemtoRegE,
  input logic                   BranchTakenE,
  input armControlPkg::aluCtrlT ALUControlE
);

  timeunit 1ns;
  timeprecision 1ps;

  // M registers come out of reset cleared
  memWriteLowAfterReset: assert property (@(posedge clk) reset |=> !MemWriteM)
    else $error("MemWriteM high in the cycle after reset");

  // A flushed E stage behaves as a bubble
  flushClearsE: assert property (@(posedge clk) disable iff (reset)
    FlushE |=> (!ALUSrcE && !MemtoRegE && !BranchTakenE && (ALUControlE == '0)))
    else $error("E stage controls not cleared after FlushE");

  stallHoldsM: assert property (@(posedge clk) disable iff (reset)
    StallM |=> $stable({MemWriteM, MemtoRegM, RegWriteM}))
    else $error("M stage controls changed during StallM");

endmodule

/* test/armControlTb.sv */
module armControlTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int resetCycles  = 5;
  localparam int decodeCycles = 48;
  localparam int flagCycles   = 48;
  localparam int propCycles   = 40;
  localparam int hazardCycles = 64;
  localparam int stallCycles  = 32;
  localparam int drainCycles  = 4;
  localparam int cycleLimit   = 2 * (resetCycles + decodeCycles + flagCycles + propCycles +
                                     hazardCycles + stallCycles + drainCycles);

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;
    logic       memtoReg;
    logic [1:0] flagWrite;
    logic [3:0] cond;
    logic       aluSrc;
    logic [3:0] aluCtrl;
    logic       rselect;
    logic [1:0] resultSel;
    logic       prevRsr;
    logic [2:0] shiftOp;
  } ctrlT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       mult;
    ctrlT       ctrl;
  } decodeT;

  typedef struct packed {
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic       stallF, stallD, stallE, stallM, flushD, flushE, flushW;
  } hazT;

  logic                   clk = 1'b0;
  logic                   reset = 1'b1;
  armControlPkg::instrT   InstrD = '0;
  armControlPkg::flagsT   ALUFlagsE = '0;
  logic                   doNotWriteReg = 1'b0;
  logic                   prevRSRstateD = 1'b0;
  armControlPkg::shiftOpT shiftOpCodeD = '0;
  logic                   Match1EM = 1'b0;
  logic                   Match2EM = 1'b0;
  logic                   Match1EW = 1'b0;
  logic                   Match2EW = 1'b0;
  logic                   Match12DE = 1'b0;
  logic                   memBusy = 1'b0;

  armControlPkg::regSrcT  RegSrcD;
  armControlPkg::immSrcT  ImmSrcD;
  armControlPkg::aluCtrlT ALUControlE;
  armControlPkg::shiftOpT shiftOpCodeE;
  armControlPkg::fwdSelT  ForwardAE, ForwardBE;
  logic [1:0]             previousCVflag, resultSelectE;
  logic                   ALUSrcE, BranchTakenE, MemWriteM, MemtoRegE, MemtoRegM, MemtoRegW;
  logic                   RegWriteM, RegWriteW, PCSrcW, PCWrPendingF, RselectE, prevRSRstateE;
  logic                   multSelect, StallF, StallD, FlushD;

  int          cycleCount = 0;
  logic [31:0] seed = 32'h98c16f7e;
  ctrlT        expPipe [3];  // E, M, W
  logic [3:0]  expFlags;

  armControlTop u_dut (.*);

  bind controller pipelineChecks pipeChecks (
    .clk(clk), .reset(reset), .FlushE(FlushE), .StallM(StallM), .MemWriteM(MemWriteM),
    .MemtoRegM(MemtoRegM), .RegWriteM(RegWriteM), .ALUSrcE(ALUSrcE), .MemtoRegE(MemtoRegE),
    .BranchTakenE(BranchTakenE), .ALUControlE(ALUControlE)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic decodeT decodeRef(input logic [31:4] ins, input logic [6:4] shOp,
                                       input logic rsr);
    decodeT d;
    logic   dpClass;
    d = '0;
    dpClass        = (ins[27:25] == 3'b000);
    d.ctrl.cond    = ins[31:28];
    d.ctrl.aluCtrl = 4'b0100;  // ADD unless the opcode field applies
    d.ctrl.rselect = dpClass && !shOp[4];
    d.ctrl.prevRsr = rsr;
    d.ctrl.shiftOp = shOp;
    case (ins[27:26])
      2'b00: begin  // DP and multiply with S setting both flag groups
        d.mult           = !ins[25] && ins[7] && ins[4];
        d.ctrl.aluSrc    = ins[25];
        d.ctrl.aluCtrl   = ins[24:21];
        d.ctrl.regWrite  = 1'b1;
        d.ctrl.flagWrite = {ins[20], ins[20]};
      end
      2'b01: begin  // L bit picks load or store
        d.immSrc        = 2'b01;
        d.regSrc        = ins[20] ? 2'b00 : 2'b10;
        d.ctrl.aluSrc   = 1'b1;
        d.ctrl.regWrite = ins[20];
        d.ctrl.memtoReg = ins[20];
        d.ctrl.memWrite = !ins[20];
      end
      2'b10: begin
        d.immSrc      = 2'b10;
        d.regSrc      = 2'b01;
        d.ctrl.aluSrc = 1'b1;
        d.ctrl.branch = 1'b1;
      end
      default: ;  // Bubble
    endcase
    d.ctrl.resultSel = {d.mult, dpClass && shOp[4]};
    d.ctrl.pcSrc     = d.ctrl.branch || (d.ctrl.regWrite && (ins[15:12] == 4'hf));
    return d;
  endfunction

  function automatic logic condRef(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v;
    logic res;
    {n, z, c, v} = f;
    case (cond)
      4'd0:    res = z;
      4'd1:    res = !z;
      4'd2:    res = c;
      4'd3:    res = !c;
      4'd4:    res = n;
      4'd5:    res = !n;
      4'd6:    res = v;
      4'd7:    res = !v;
      4'd8:    res = c && !z;            // HI
      4'd9:    res = !c || z;
      4'd10:   res = (n == v);           // GE
      4'd11:   res = (n != v);
      4'd12:   res = !z && (n == v);
      4'd13:   res = z || (n != v);
      4'd14:   res = 1'b1;
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  function automatic logic [3:0] flagsRef(input logic [3:0] cond, input logic [3:0] f,
                                          input logic [3:0] alu, input logic [1:0] fw);
    logic [3:0] nxt;
    nxt = f;
    if (condRef(cond, f) && fw[1]) nxt[3:2] = alu[3:2];
    if (condRef(cond, f) && fw[0]) nxt[1:0] = alu[1:0];
    return nxt;
  endfunction

  function automatic logic [1:0] fwdRef(input logic matchM, input logic matchW,
                                        input logic rwM, input logic rwW);
    if (matchM && rwM) return 2'd2;
    if (matchW && rwW) return 2'd1;
    return 2'd0;
  endfunction

  // m holds {1EM, 2EM, 1EW, 2EW, 12DE}
  function automatic hazT hazardRef(input logic [4:0] m, input logic rwM, input logic rwW,
                                    input logic mtrE, input logic pcPend, input logic pcSrcW,
                                    input logic brTaken, input logic busy);
    hazT  h;
    logic ldr;
    ldr      = m[0] && mtrE;
    h.fwdA   = fwdRef(m[4], m[2], rwM, rwW);
    h.fwdB   = fwdRef(m[3], m[1], rwM, rwW);
    h.stallF = busy || ldr || (pcPend && !pcSrcW);
    h.stallD = busy || ldr;
    h.stallE = busy;
    h.stallM = busy;
    h.flushD = !busy && (pcPend || pcSrcW || brTaken);
    h.flushE = !busy && (ldr || brTaken);
    h.flushW = busy;
    return h;
  endfunction

  task automatic checkValue(input string name, input logic [3:0] actual,
                            input logic [3:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Outputs are stable at the falling edge before the model steps
  always @(negedge clk) begin : compareOutputs
    decodeT dec;
    hazT    hz;
    logic   condOk;
    logic   pcPend;
    if (reset) begin
      expPipe[0] = '0;
      expPipe[1] = '0;
      expPipe[2] = '0;
      expFlags   = '0;
    end else begin
      dec    = decodeRef(InstrD, shiftOpCodeD, prevRSRstateD);
      condOk = condRef(expPipe[0].cond, expFlags);
      pcPend = dec.ctrl.pcSrc || expPipe[0].pcSrc || expPipe[1].pcSrc;
      hz     = hazardRef({Match1EM, Match2EM, Match1EW, Match2EW, Match12DE},
                         expPipe[1].regWrite, expPipe[2].regWrite, expPipe[0].memtoReg,
                         pcPend, expPipe[2].pcSrc, expPipe[0].branch && condOk, memBusy);
      checkValue("RegSrcD", 4'(RegSrcD), 4'(dec.regSrc));
      checkValue("ImmSrcD", 4'(ImmSrcD), 4'(dec.immSrc));
      checkValue("multSelect", 4'(multSelect), 4'(dec.mult));
      checkValue("BranchTakenE", 4'(BranchTakenE), 4'(expPipe[0].branch && condOk));
      checkValue("MemtoRegE", 4'(MemtoRegE), 4'(expPipe[0].memtoReg));
      checkValue("ALUSrcE", 4'(ALUSrcE), 4'(expPipe[0].aluSrc));
      checkValue("ALUControlE", ALUControlE, expPipe[0].aluCtrl);
      checkValue("RselectE", 4'(RselectE), 4'(expPipe[0].rselect));
      checkValue("resultSelectE", 4'(resultSelectE), 4'(expPipe[0].resultSel));
      checkValue("prevRSRstateE", 4'(prevRSRstateE), 4'(expPipe[0].prevRsr));
      checkValue("shiftOpCodeE", 4'(shiftOpCodeE), 4'(expPipe[0].shiftOp));
      checkValue("MemtoRegM", 4'(MemtoRegM), 4'(expPipe[1].memtoReg));
      checkValue("MemWriteM", 4'(MemWriteM), 4'(expPipe[1].memWrite));
      checkValue("RegWriteM", 4'(RegWriteM), 4'(expPipe[1].regWrite));
      checkValue("MemtoRegW", 4'(MemtoRegW), 4'(expPipe[2].memtoReg));
      checkValue("RegWriteW", 4'(RegWriteW), 4'(expPipe[2].regWrite));
      checkValue("PCSrcW", 4'(PCSrcW), 4'(expPipe[2].pcSrc));
      checkValue("PCWrPendingF", 4'(PCWrPendingF), 4'(pcPend));
      checkValue("previousCVflag", 4'(previousCVflag), 4'(expFlags[1:0]));
      checkValue("StallF", 4'(StallF), 4'(hz.stallF));
      checkValue("StallD", 4'(StallD), 4'(hz.stallD));
      checkValue("FlushD", 4'(FlushD), 4'(hz.flushD));
      checkValue("ForwardAE", 4'(ForwardAE), 4'(hz.fwdA));
      checkValue("ForwardBE", 4'(ForwardBE), 4'(hz.fwdB));
      // Advance W then M then flags and E from the older stage
      expPipe[2] = hz.flushW ? '0 : expPipe[1];
      if (!hz.stallM) begin
        expPipe[1]          = expPipe[0];
        expPipe[1].regWrite = expPipe[0].regWrite && condOk && !doNotWriteReg;
        expPipe[1].memWrite = expPipe[0].memWrite && condOk;
        expPipe[1].pcSrc    = expPipe[0].pcSrc && condOk;
      end
      if (!hz.stallE) expFlags = flagsRef(expPipe[0].cond, expFlags, ALUFlagsE,
                                          expPipe[0].flagWrite);
      if (hz.flushE) expPipe[0] = '0;
      else if (!hz.stallE) expPipe[0] = dec.ctrl;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: stimulus still running after %0d cycles", cycleCount);
      $display("TESTS FAILED");
      $fatal(1, "Simulation timeout");
    end
  end

  // Kinds 0 DP imm, 1 DP reg, 2 MUL, 3 LDR, 4 STR, others B
  function automatic logic [31:0] makeInstr(input int kind, input logic [31:0] r);
    logic [31:0] w;
    w = r;
    case (kind)
      0: w[27:25] = 3'b001;
      1: begin
        w[27:25] = 3'b000;
        w[7]     = 1'b0;
      end
      2: begin
        w[27:25] = 3'b000;
        w[7]     = 1'b1;
        w[4]     = 1'b1;
      end
      3: {w[27:26], w[20]} = 3'b011;
      4: {w[27:26], w[20]} = 3'b010;
      default: w[27:25] = 3'b101;
    endcase
    return w;
  endfunction

  task automatic applyCycle(input logic [31:0] word, input logic [3:0] aluFlags,
                            input logic dnw, input logic [4:0] match, input logic busy);
    @(posedge clk);
    InstrD        <= word[31:4];
    shiftOpCodeD  <= word[6:4];
    prevRSRstateD <= word[3];
    ALUFlagsE     <= aluFlags;
    doNotWriteReg <= dnw;
    {Match1EM, Match2EM, Match1EW, Match2EW, Match12DE} <= match;
    memBusy       <= busy;
  endtask

  task automatic randomCycles(input int n, input int phase);
    logic [31:0] r, s, w;
    for (int i = 0; i < n; i++) begin
      seed = lcgNext(seed);
      r    = seed;
      seed = lcgNext(seed);
      s    = seed;
      case (phase)
        0: applyCycle(makeInstr(i % 6, r), s[3:0], 1'b0, 5'd0, 1'b0);
        1: begin  // Flag setter then a conditional branch
          w = makeInstr((i % 2 == 0) ? 0 : 5, r);
          if (i % 2 == 0) w[20] = 1'b1;
          applyCycle(w, s[3:0], 1'b0, 5'd0, 1'b0);
        end
        2: begin
          w = makeInstr((s[17:16] == 2'd0) ? 1 : ((s[17:16] == 2'd1) ? 3 : 4), r);
          w[31:28] = armControlPkg::condAl;
          applyCycle(w, s[3:0], s[8], 5'd0, 1'b0);
        end
        3: applyCycle(makeInstr(int'(s[18:16]) % 6, r), s[3:0], s[4], s[9:5],
                      s[12:10] == 3'd0);
        default: applyCycle(makeInstr(i % 6, r), s[3:0], 1'b0, s[9:5],
                            ((i % 8) >= 3) && ((i % 8) < 7));
      endcase
    end
  endtask

  initial begin
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkValue("RegWriteM", 4'(RegWriteM), 4'd0);
    checkValue("MemWriteM", 4'(MemWriteM), 4'd0);
    checkValue("RegWriteW", 4'(RegWriteW), 4'd0);
    checkValue("PCSrcW", 4'(PCSrcW), 4'd0);
    checkValue("BranchTakenE", 4'(BranchTakenE), 4'd0);
    randomCycles(decodeCycles, 0);
    randomCycles(flagCycles, 1);
    randomCycles(propCycles, 2);
    randomCycles(hazardCycles, 3);
    randomCycles(stallCycles, 4);
    repeat (drainCycles) applyCycle(32'hec00_0000, 4'h0, 1'b0, 5'd0, 1'b0);  // Bubbles
    @(negedge clk);
    #1;
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* armControl.f */
common/armControlPkg.sv
controller/instrDecoder.sv
controller/condUnit.sv
controller/controller.sv
source/hazardUnit.sv
source/armControlTop.sv
test/armControlTb_assert.sv
test/armControlTb.sv

/* Makefile */
TOP = armControlTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f armControl.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
